// File: project.f
+incdir+test
logic/fpu_pkg.sv
logic/fadd.sv
logic/fdiv.sv
logic/fsqrt.sv
logic/fpu_ctrl.sv
logic/fpu_top.sv
test/tb_fpu.sv

// File: run.sh
#!/bin/sh
# build and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_fpu -Mdir obj_dir -f project.f || exit 1
./obj_dir/Vtb_fpu > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -qx '=== PASS ===' sim.log && exit 0 || exit 1

// File: test/fpu_model.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// exponent range of random operands, all normal
localparam int EXP_LO = 64;
localparam int EXP_HI = 190;

// truncating add, denormals flushed, no guard bits
function automatic logic [31:0] trunc_add(input logic [31:0] a, input logic [31:0] b);
  logic [31:0] hi;
  logic [31:0] lo;
  int          mh;
  int          ml;
  int          shift;
  int          sum;
  int          e;
  hi    = (b[30:0] > a[30:0]) ? b : a;
  lo    = (b[30:0] > a[30:0]) ? a : b;
  e     = int'(hi[30:23]);
  mh    = (hi[30:23] == 0) ? 0 : ((1 << MAN_W) | int'(hi[22:0]));
  ml    = (lo[30:23] == 0) ? 0 : ((1 << MAN_W) | int'(lo[22:0]));
  shift = e - int'(lo[30:23]);
  // bits shifted out of the smaller operand are lost
  ml    = (shift > MAN_W + 1) ? 0 : (ml >> shift);
  sum   = (hi[31] != lo[31]) ? mh - ml : mh + ml;
  if (sum == 0) return 32'd0;
  if (sum >= (1 << (MAN_W + 1))) return {hi[31], 8'(e + 1), 23'(sum >> 1)};
  while (sum < (1 << MAN_W)) begin
    sum = sum << 1;
    e   = e - 1;
  end
  if (e <= 0) return 32'd0;
  return {hi[31], 8'(e), 23'(sum)};
endfunction

// truncating divide, zero dividend gives +0
function automatic logic [31:0] trunc_div(input logic [31:0] a, input logic [31:0] b);
  longint q;
  int     e;
  if (a[30:23] == 0) return 32'd0;
  q = (longint'((1 << MAN_W) | int'(a[22:0])) << (MAN_W + 1))
      / longint'((1 << MAN_W) | int'(b[22:0]));
  e = int'(a[30:23]) - int'(b[30:23]) + BIAS;
  // quotient below one needs one more bit of shift
  if (q < (longint'(1) << (MAN_W + 1))) begin
    q = q << 1;
    e = e - 1;
  end
  if (e <= 0) return 32'd0;
  return {a[31] ^ b[31], 8'(e), 23'(q >> 1)};
endfunction

function automatic logic [31:0] halve_float(input logic [31:0] x);
  return {1'b0, x[30:23] - 8'd1, x[22:0]};
endfunction

// halved exponent, top mantissa bits from exponent parity
function automatic logic [31:0] sqrt_seed(input logic [31:0] a);
  int   biased;
  logic odd;
  logic mt;
  biased = int'(a[30:23]) + BIAS;
  odd    = biased[0];
  mt     = a[22];
  return {1'b0, 8'((biased >> 1) + int'(odd & mt)), mt ^ odd, ~mt, 21'd0};
endfunction

// three newton steps of x/2 + (a/2)/x
function automatic logic [31:0] newton_sqrt(input logic [31:0] a);
  logic [31:0] half_a;
  logic [31:0] x;
  if (a[30:23] == 0) return 32'd0;
  half_a = (a[30:23] > 8'd1) ? halve_float(a) : 32'd0;
  x      = sqrt_seed(a);
  for (int i = 0; i < 3; i++) begin
    x = trunc_add(halve_float(x), trunc_div(half_a, x));
  end
  return x;
endfunction

`endif

// File: test/tb_fpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpu;
  import fpu_pkg::*;

  `include "fpu_model.svh"

  localparam int RESET_CYCLES = 16;
  localparam int N_OPS        = 200 + 201 + 100 + 5 + 24 + 12;
  localparam int MAX_CYCLES   = N_OPS * 400 + RESET_CYCLES;

  logic     clk;
  logic     rstn;
  logic     order;
  fpu_cmd_t cmd;
  logic     accepted;
  logic     done;
  fpu_rsp_t rsp;

  fpu_cmd_t cmds[$];
  fpu_rsp_t exps[$];
  int       cycle;
  int       errors;
  int       tests;

  fpu_top fpu_top_i (.clk(clk), .rstn(rstn), .order(order), .cmd(cmd),
                     .accepted(accepted), .done(done), .rsp(rsp));

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: a done never came within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] model_rd(input fpu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
      FADD:    return trunc_add(a, b);
      FSUB:    return trunc_add(a, {~b[31], b[30:0]});
      FDIV:    return trunc_div(a, b);
      default: return newton_sqrt(a);
    endcase
  endfunction

  function automatic logic [31:0] rand_float(input int elo, input int ehi, input bit pos);
    logic [7:0] e;
    e = 8'(elo + int'($urandom % (ehi - elo + 1)));
    return {pos ? 1'b0 : 1'($urandom), e, 23'($urandom)};
  endfunction

  task automatic queue_op(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] rd);
    fpu_cmd_t c;
    fpu_rsp_t r;
    c.op  = op;
    c.rs1 = a;
    c.rs2 = b;
    r.op  = op;
    r.rd  = rd;
    cmds.push_back(c);
    exps.push_back(r);
  endtask

  // b2b keeps order high with the next command while one is in flight
  task automatic run_queue(input string name, input bit b2b);
    fpu_rsp_t flight[$];
    int       acc_cyc[$];
    fpu_rsp_t want;
    int       lat;
    int       total;
    int       fails;
    total = cmds.size();
    fails = 0;
    while (cmds.size() > 0 || flight.size() > 0) begin
      @(negedge clk);
      if (cmds.size() > 0 && (b2b || flight.size() == 0)) begin
        cmd   = cmds[0];
        order = 1'b1;
      end else begin
        order = 1'b0;
      end
      #1;
      if (done) begin
        if (flight.size() == 0) begin
          $display("%s: done arrived with no command in flight", name);
          fails++;
        end else begin
          want = flight.pop_front();
          lat  = cycle - acc_cyc.pop_front();
          if (rsp !== want) begin
            $display("Fail %s expected %h actual %h", name, want, rsp);
            fails++;
          end
          if (want.op == FDIV && lat != 28) begin
            $display("%s: divide took %0d cycles from accepted to done, not 28", name, lat);
            fails++;
          end
        end
      end
      if (accepted) begin
        if (flight.size() > 0) begin
          $display("%s: accepted rose while a result was still pending", name);
          fails++;
        end
        flight.push_back(exps.pop_front());
        acc_cyc.push_back(cycle);
        void'(cmds.pop_front());
      end
    end
    @(negedge clk);
    order = 1'b0;
    $display("%s: %0d ops, %0d failed", name, total, fails);
    errors += fails;
    tests++;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    fpu_op_e     op;
    clk    = 1'b0;
    rstn   = 1'b0;
    order  = 1'b0;
    cmd    = '0;
    cycle  = 0;
    errors = 0;
    tests  = 0;
    void'($urandom(96233));
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;

    for (int i = 0; i < 200; i++) begin
      if (i % 2 == 0) op = FADD;
      else op = FSUB;
      a = rand_float(EXP_LO + 4, EXP_HI - 4, 1'b0);
      case (i % 5)
        // exact cancel
        0: b = (op == FADD) ? {~a[31], a[30:0]} : a;
        // same exponent, opposite effective sign
        1: b = {~a[31] ^ (op == FSUB), a[30:23], 23'($urandom)};
        2: b = rand_float(EXP_LO, EXP_HI, 1'b0);
        default: b = rand_float(int'(a[30:23]) - 4, int'(a[30:23]) + 4, 1'b0);
      endcase
      queue_op(op, a, b, model_rd(op, a, b));
    end
    run_queue("fadd_fsub_random", 1'b0);

    for (int i = 0; i < 200; i++) begin
      a = rand_float(EXP_LO, EXP_HI, 1'b0);
      b = rand_float(EXP_LO, EXP_HI, 1'b0);
      queue_op(FDIV, a, b, model_rd(FDIV, a, b));
    end
    run_queue("fdiv_random", 1'b0);
    queue_op(FDIV, 32'd0, rand_float(EXP_LO, EXP_HI, 1'b0), 32'd0);
    run_queue("fdiv_zero", 1'b0);

    for (int i = 0; i < 100; i++) begin
      a = rand_float(EXP_LO, EXP_HI, 1'b1);
      queue_op(FSQRT, a, 32'd0, model_rd(FSQRT, a, 32'd0));
    end
    run_queue("fsqrt_random", 1'b0);
    queue_op(FSQRT, 32'd0, 32'd0, 32'd0);
    // 1.0, 4.0, 9.0, 16.0
    queue_op(FSQRT, 32'h3f80_0000, 32'd0, model_rd(FSQRT, 32'h3f80_0000, 32'd0));
    queue_op(FSQRT, 32'h4080_0000, 32'd0, model_rd(FSQRT, 32'h4080_0000, 32'd0));
    queue_op(FSQRT, 32'h4110_0000, 32'd0, model_rd(FSQRT, 32'h4110_0000, 32'd0));
    queue_op(FSQRT, 32'h4180_0000, 32'd0, model_rd(FSQRT, 32'h4180_0000, 32'd0));
    run_queue("fsqrt_special", 1'b0);

    for (int i = 0; i < 24; i++) begin
      op = fpu_op_e'($urandom % 4);
      a  = rand_float(EXP_LO, EXP_HI, op == FSQRT);
      b  = rand_float(EXP_LO, EXP_HI, 1'b0);
      queue_op(op, a, b, model_rd(op, a, b));
    end
    run_queue("back_to_back", 1'b1);

    for (int i = 0; i < 4; i++) begin
      a = {1'($urandom), 8'd0, 23'($urandom) | 23'd1};
      b = rand_float(EXP_LO, EXP_HI, 1'b0);
      queue_op(FADD, a, b, b);
      queue_op(FADD, b, a, b);
      queue_op(FDIV, a, b, 32'd0);
    end
    run_queue("denormal_flush", 1'b0);

    $display("tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  wire               clk,
  input  wire               rstn,
  input  wire               order,
  input  fpu_pkg::fpu_cmd_t cmd,
  output wire               accepted,
  output wire               done,
  output fpu_pkg::fpu_rsp_t rsp
);

  wire        add_order, add_accepted, add_done;
  wire        div_order, div_accepted, div_done;
  wire        sqrt_order, sqrt_accepted, sqrt_done;
  wire [31:0] add_rd, div_rd, sqrt_rd;
  wire [31:0] op_a, op_b;

  fpu_ctrl u_ctrl (
    .clk(clk), .rstn(rstn), .order(order), .cmd(cmd),
    .accepted(accepted), .done(done), .rsp(rsp),
    .add_order(add_order), .add_accepted(add_accepted),
    .add_done(add_done), .add_rd(add_rd),
    .div_order(div_order), .div_accepted(div_accepted),
    .div_done(div_done), .div_rd(div_rd),
    .sqrt_order(sqrt_order), .sqrt_accepted(sqrt_accepted),
    .sqrt_done(sqrt_done), .sqrt_rd(sqrt_rd),
    .op_a(op_a), .op_b(op_b)
  );

  fadd u_fadd (.clk(clk), .rstn(rstn), .order(add_order), .accepted(add_accepted),
               .done(add_done), .rs1(op_a), .rs2(op_b), .rd(add_rd));

  fdiv u_fdiv (.clk(clk), .rstn(rstn), .order(div_order), .accepted(div_accepted),
               .done(div_done), .rs1(op_a), .rs2(op_b), .rd(div_rd));

  fsqrt u_fsqrt (.clk(clk), .rstn(rstn), .order(sqrt_order), .accepted(sqrt_accepted),
                 .done(sqrt_done), .rs1(op_a), .rd(sqrt_rd));

endmodule

`default_nettype wire

// File: logic/fpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ctrl (
  input  logic              clk,
  input  logic              rstn,
  input  logic              order,
  input  fpu_pkg::fpu_cmd_t cmd,
  output logic              accepted,
  output logic              done,
  output fpu_pkg::fpu_rsp_t rsp,
  output logic              add_order,
  input  logic              add_accepted,
  input  logic              add_done,
  input  logic [31:0]       add_rd,
  output logic              div_order,
  input  logic              div_accepted,
  input  logic              div_done,
  input  logic [31:0]       div_rd,
  output logic              sqrt_order,
  input  logic              sqrt_accepted,
  input  logic              sqrt_done,
  input  logic [31:0]       sqrt_rd,
  output logic [31:0]       op_a,
  output logic [31:0]       op_b
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_e;

  state_e      state;
  fpu_cmd_t    cur;
  logic        unit_acc;
  logic        unit_done;
  logic [31:0] unit_rd;

  assign accepted = order && (state == IDLE);
  assign op_a     = cur.rs1;
  assign op_b     = cur.rs2;

  assign add_order  = (state == ISSUE) && (cur.op == FADD || cur.op == FSUB);
  assign div_order  = (state == ISSUE) && (cur.op == FDIV);
  assign sqrt_order = (state == ISSUE) && (cur.op == FSQRT);

  // pick the handshake of the unit owning the current op
  always_comb begin
    case (cur.op)
      FDIV: begin
        unit_acc  = div_accepted;
        unit_done = div_done;
        unit_rd   = div_rd;
      end
      FSQRT: begin
        unit_acc  = sqrt_accepted;
        unit_done = sqrt_done;
        unit_rd   = sqrt_rd;
      end
      default: begin
        unit_acc  = add_accepted;
        unit_done = add_done;
        unit_rd   = add_rd;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      done <= (state == WAIT) && unit_done;
      case (state)
        IDLE:    if (accepted) state <= ISSUE;
        ISSUE:   if (unit_acc) state <= WAIT;
        default: if (unit_done) state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      cur.op  <= cmd.op;
      cur.rs1 <= cmd.rs1;
      // subtract is add with rs2 negated
      cur.rs2 <= {cmd.rs2[31] ^ (cmd.op == FSUB), cmd.rs2[30:0]};
    end
    if (state == WAIT && unit_done) begin
      rsp.op <= cur.op;
      rsp.rd <= unit_rd;
    end
  end

  // only one unit may take an order in a cycle
  a_order_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({add_accepted, div_accepted, sqrt_accepted}));

  a_no_idle_done: assert property (@(posedge clk) disable iff (!rstn)
    (state == IDLE) |-> !(add_done || div_done || sqrt_done));

endmodule

`default_nettype wire

// File: logic/fsqrt.sv
`timescale 1ns/1ps
`default_nettype none

module fsqrt (
  input  logic        clk,
  input  logic        rstn,
  input  logic        order,
  output logic        accepted,
  output logic        done,
  input  logic [31:0] rs1,
  output logic [31:0] rd
);
  import fpu_pkg::*;

  // x/2 by exponent decrement
  function automatic logic [31:0] halve(input logic [31:0] x);
    halve = {1'b0, x[MAN_W +: EXP_W] - EXP_W'(1), x[MAN_W-1:0]};
  endfunction

  logic             busy;
  logic [EXP_W-1:0] e1;
  logic             m_top;
  logic [EXP_W:0]   e_sum;
  logic             par;
  logic [31:0]      seed;
  logic [31:0]      half_a;

  logic stage_0, stage_1, stage_2, stage_3, stage_4, stage_5, stage_6;
  logic adv_0, adv_1, adv_2, adv_3, adv_4, adv_5;
  logic d1_order, d1_acc, d1_done, a1_order, a1_acc, a1_done;
  logic d2_order, d2_acc, d2_done, a2_order, a2_acc, a2_done;
  logic d3_order, d3_acc, d3_done, a3_order, a3_acc, a3_done;
  logic [31:0] d1_rd, a1_rd, d2_rd, a2_rd, d3_rd, a3_rd;

  logic [31:0] a_0, x_0, a_1, xh_1, q_1, a_2, x_2, a_3, xh_3, q_3;
  logic [31:0] a_4, x_4, xh_5, q_5, rd_6;
  logic        z_0, z_1, z_2, z_3, z_4, z_5, z_6;

  assign accepted = order & ~busy;
  assign done     = stage_6;
  assign rd       = z_6 ? 32'd0 : rd_6;

  // seed: (e1 - bias)/2 + bias folds into (e1 + bias)/2, parity picks the mantissa
  assign e1     = rs1[MAN_W +: EXP_W];
  assign m_top  = rs1[MAN_W-1];
  assign e_sum  = {1'b0, e1} + (EXP_W+1)'(BIAS);
  assign par    = e_sum[0];
  assign seed   = {1'b0, e_sum[EXP_W:1] + EXP_W'(par & m_top), m_top ^ par, ~m_top,
                   {(MAN_W-2){1'b0}}};
  assign half_a = (e1 > EXP_W'(1)) ? halve(rs1) : 32'd0;

  // a stage moves on when its unit finishes or it is empty
  assign adv_0 = d1_done | ~stage_0;
  assign adv_1 = a1_done | ~stage_1;
  assign adv_2 = d2_done | ~stage_2;
  assign adv_3 = a2_done | ~stage_3;
  assign adv_4 = d3_done | ~stage_4;
  assign adv_5 = a3_done | ~stage_5;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy     <= 1'b0;
      d1_order <= 1'b0;
      a1_order <= 1'b0;
      d2_order <= 1'b0;
      a2_order <= 1'b0;
      d3_order <= 1'b0;
      a3_order <= 1'b0;
      stage_0  <= 1'b0;
      stage_1  <= 1'b0;
      stage_2  <= 1'b0;
      stage_3  <= 1'b0;
      stage_4  <= 1'b0;
      stage_5  <= 1'b0;
      stage_6  <= 1'b0;
    end else begin
      busy     <= busy ? ~done : accepted;
      // orders hold until the unit takes them
      d1_order <= (d1_order & ~d1_acc) | (accepted & ~stage_0);
      a1_order <= (a1_order & ~a1_acc) | (d1_done & ~stage_1);
      d2_order <= (d2_order & ~d2_acc) | (a1_done & ~stage_2);
      a2_order <= (a2_order & ~a2_acc) | (d2_done & ~stage_3);
      d3_order <= (d3_order & ~d3_acc) | (a2_done & ~stage_4);
      a3_order <= (a3_order & ~a3_acc) | (d3_done & ~stage_5);
      if (adv_0) stage_0 <= accepted;
      if (adv_1) stage_1 <= d1_done;
      if (adv_2) stage_2 <= a1_done;
      if (adv_3) stage_3 <= d2_done;
      if (adv_4) stage_4 <= a2_done;
      if (adv_5) stage_5 <= d3_done;
      stage_6 <= a3_done;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_0) begin
      a_0 <= half_a;
      x_0 <= seed;
      z_0 <= e1 == '0;
    end
    if (adv_1) begin
      a_1  <= a_0;
      xh_1 <= halve(x_0);
      q_1  <= d1_rd;
      z_1  <= z_0;
    end
    if (adv_2) begin
      a_2 <= a_1;
      x_2 <= a1_rd;
      z_2 <= z_1;
    end
    if (adv_3) begin
      a_3  <= a_2;
      xh_3 <= halve(x_2);
      q_3  <= d2_rd;
      z_3  <= z_2;
    end
    if (adv_4) begin
      a_4 <= a_3;
      x_4 <= a2_rd;
      z_4 <= z_3;
    end
    if (adv_5) begin
      xh_5 <= halve(x_4);
      q_5  <= d3_rd;
      z_5  <= z_4;
    end
    rd_6 <= a3_rd;
    z_6  <= z_5;
  end

  // newton step i: (a/2)/x then x/2 + quotient
  fdiv u_div1 (.clk(clk), .rstn(rstn), .order(d1_order), .accepted(d1_acc),
               .done(d1_done), .rs1(a_0), .rs2(x_0), .rd(d1_rd));
  fadd u_add1 (.clk(clk), .rstn(rstn), .order(a1_order), .accepted(a1_acc),
               .done(a1_done), .rs1(xh_1), .rs2(q_1), .rd(a1_rd));
  fdiv u_div2 (.clk(clk), .rstn(rstn), .order(d2_order), .accepted(d2_acc),
               .done(d2_done), .rs1(a_2), .rs2(x_2), .rd(d2_rd));
  fadd u_add2 (.clk(clk), .rstn(rstn), .order(a2_order), .accepted(a2_acc),
               .done(a2_done), .rs1(xh_3), .rs2(q_3), .rd(a2_rd));
  fdiv u_div3 (.clk(clk), .rstn(rstn), .order(d3_order), .accepted(d3_acc),
               .done(d3_done), .rs1(a_4), .rs2(x_4), .rd(d3_rd));
  fadd u_add3 (.clk(clk), .rstn(rstn), .order(a3_order), .accepted(a3_acc),
               .done(a3_done), .rs1(xh_5), .rs2(q_5), .rd(a3_rd));

  a_done_src: assert property (@(posedge clk) disable iff (!rstn)
    done |-> $past(stage_5));

endmodule

`default_nettype wire

// File: logic/fdiv.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv (
  input  logic        clk,
  input  logic        rstn,
  input  logic        order,
  output logic        accepted,
  output logic        done,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  output logic [31:0] rd
);
  import fpu_pkg::*;

  logic                             busy;
  logic [$clog2(DIV_STEPS+1)-1:0]   cnt;
  logic [MAN_W+1:0]                 rem;
  logic [MAN_W:0]                   dvs;
  logic [DIV_STEPS-1:0]             quo;
  logic                             sign;
  logic                             zero;
  // two spare bits so a negative exponent shows in the msb
  logic [EXP_W+1:0]                 exp_q;
  logic [EXP_W+1:0]                 exp_r;
  logic                             ge;

  assign accepted = order & ~busy;
  assign done     = busy && (cnt == DIV_STEPS);
  assign ge       = rem >= {1'b0, dvs};

  // quotient msb is the integer bit
  assign exp_r = quo[DIV_STEPS-1] ? exp_q : exp_q - 1'b1;

  always_comb begin
    if (zero || exp_r[EXP_W+1] || exp_r == '0) begin
      rd = '0;
    end else if (quo[DIV_STEPS-1]) begin
      rd = {sign, exp_r[EXP_W-1:0], quo[DIV_STEPS-2:1]};
    end else begin
      rd = {sign, exp_r[EXP_W-1:0], quo[DIV_STEPS-3:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (accepted) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (done) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      rem   <= {2'b01, rs1[MAN_W-1:0]};
      dvs   <= {1'b1, rs2[MAN_W-1:0]};
      quo   <= '0;
      sign  <= rs1[31] ^ rs2[31];
      zero  <= rs1[MAN_W +: EXP_W] == '0;
      exp_q <= {2'b00, rs1[MAN_W +: EXP_W]} - {2'b00, rs2[MAN_W +: EXP_W]}
               + (EXP_W+2)'(BIAS);
    end else if (busy && !done) begin
      // restoring step, one quotient bit
      rem <= (ge ? rem - {1'b0, dvs} : rem) << 1;
      quo <= {quo[DIV_STEPS-2:0], ge};
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (!rstn)
    cnt <= DIV_STEPS);

endmodule

`default_nettype wire

// File: logic/fadd.sv
`timescale 1ns/1ps
`default_nettype none

module fadd (
  input  logic        clk,
  input  logic        rstn,
  input  logic        order,
  output logic        accepted,
  output logic        done,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  output logic [31:0] rd
);
  import fpu_pkg::*;

  typedef struct packed {
    logic             sign;
    logic             sub;
    logic [EXP_W-1:0] exp;
    logic [MAN_W:0]   mb;
    logic [MAN_W:0]   ms;
  } align_t;

  // significand with hidden bit, denormals flushed
  function automatic logic [MAN_W:0] sig(input logic [31:0] x);
    sig = (x[MAN_W +: EXP_W] == '0) ? '0 : {1'b1, x[MAN_W-1:0]};
  endfunction

  function automatic logic [4:0] lzc(input logic [MAN_W:0] v);
    lzc = 5'(MAN_W + 1);
    for (int i = 0; i <= MAN_W; i++) begin
      if (v[i]) begin
        lzc = 5'(MAN_W - i);
      end
    end
  endfunction

  logic             v1;
  align_t           s1;
  align_t           s1_next;
  logic [31:0]      op_hi;
  logic [31:0]      op_lo;
  logic [EXP_W-1:0] shamt;
  logic [MAN_W+1:0] sum;
  logic [4:0]       lz;
  logic [MAN_W:0]   norm;
  logic [31:0]      res;

  assign accepted = order & ~v1 & ~done;

  // stage 1: order by magnitude, then align the smaller one
  always_comb begin
    if (rs2[30:0] > rs1[30:0]) begin
      op_hi = rs2;
      op_lo = rs1;
    end else begin
      op_hi = rs1;
      op_lo = rs2;
    end
    shamt        = op_hi[MAN_W +: EXP_W] - op_lo[MAN_W +: EXP_W];
    s1_next.sign = op_hi[31];
    s1_next.sub  = op_hi[31] ^ op_lo[31];
    s1_next.exp  = op_hi[MAN_W +: EXP_W];
    s1_next.mb   = sig(op_hi);
    s1_next.ms   = sig(op_lo) >> shamt;
  end

  // stage 2: add, renormalize, truncate
  always_comb begin
    sum  = s1.sub ? {1'b0, s1.mb} - {1'b0, s1.ms} : {1'b0, s1.mb} + {1'b0, s1.ms};
    lz   = lzc(sum[MAN_W:0]);
    norm = sum[MAN_W:0] << lz;
    if (sum[MAN_W+1]) begin
      res = {s1.sign, s1.exp + EXP_W'(1), sum[MAN_W:1]};
    end else if (sum == '0 || s1.exp <= EXP_W'(lz)) begin
      // exact cancel or underflow
      res = '0;
    end else begin
      res = {s1.sign, s1.exp - EXP_W'(lz), norm[MAN_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1   <= 1'b0;
      done <= 1'b0;
    end else begin
      v1   <= accepted;
      done <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      s1 <= s1_next;
    end
    if (v1) begin
      rd <= res;
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
    accepted |=> !accepted ##1 (done && !accepted));

endmodule

`default_nettype wire

// File: logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // single-precision field widths
  localparam int EXP_W = 8;
  localparam int MAN_W = 23;
  localparam int BIAS  = 127;

  // quotient bits per division, integer bit included
  localparam int DIV_STEPS = 25;

  typedef enum logic [1:0] {
    FADD  = 2'd0,
    FSUB  = 2'd1,
    FDIV  = 2'd2,
    FSQRT = 2'd3
  } fpu_op_e;

  // request as seen at the top level
  typedef struct packed {
    fpu_op_e     op;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } fpu_cmd_t;

  // result with the op echoed back
  typedef struct packed {
    fpu_op_e     op;
    logic [31:0] rd;
  } fpu_rsp_t;

endpackage

`default_nettype wire
